// ==== design/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

	// One byte on ADL, ADH or DB
	typedef logic [7:0] bus_byte_t;

	// Value shown on a bus that nobody drives
	localparam bus_byte_t BUS_IDLE = 8'h00;

	// Pattern that lets an incoming carry ripple through a byte
	localparam bus_byte_t BUS_ONES = 8'hff;

	// Undriven outputs read as BUS_IDLE instead of floating
	function automatic bus_byte_t bus_gate(
		input logic en,
		input bus_byte_t value
	);
		bus_byte_t gated;
		gated = BUS_IDLE;
		if (en) begin
			gated = value;
		end
		return gated;
	endfunction

	// Lookahead term of PCLC/PCHC
	function automatic logic byte_carry(
		input logic carry_in,
		input bus_byte_t value
	);
		return carry_in && (value == BUS_ONES);
	endfunction

endpackage

`default_nettype wire

// ==== design/pc_ctrl_pkg.sv ====
`default_nettype none

package pc_ctrl_pkg;

	// Widest program counter that the command format can address
	localparam int MAX_PC_BYTES = 4;

	// Width of the data bus byte index
	localparam int DB_SEL_W = 2;

	// One transfer command, valid only with its strobe
	typedef struct packed {
		logic                    inc;        // Add one
		logic [MAX_PC_BYTES-1:0] load_mask;  // Byte k takes its address bus
		logic                    addr_drive; // All bytes onto their address buses
		logic                    db_drive;   // One byte onto DB
		logic [DB_SEL_W-1:0]     db_sel;     // Which byte goes onto DB
	} pc_cmd_t;

	// Control of one byte slice for the current cycle
	typedef struct packed {
		logic load_ad;  // ADx -> PCx instead of PCx -> PCx
		logic drive_ad; // PCx -> ADx
	} pc_xfer_t;

	// Slice state when no command is strobed
	localparam pc_xfer_t XFER_IDLE = '{
		load_ad:  1'b0,
		drive_ad: 1'b0
	};

	// Spread a strobed command into the control of byte idx
	function automatic pc_xfer_t xfer_for_byte(
		input logic    valid,
		input pc_cmd_t cmd,
		input int      idx
	);
		pc_xfer_t xfer;
		xfer = XFER_IDLE;
		if (valid) begin
			xfer.load_ad  = cmd.load_mask[idx];
			xfer.drive_ad = cmd.addr_drive;
		end
		return xfer;
	endfunction

	// Mask of the load bits that a counter of num_bytes may use
	function automatic logic [MAX_PC_BYTES-1:0] legal_load_mask(input int num_bytes);
		return (MAX_PC_BYTES)'((1 << num_bytes) - 1);
	endfunction

endpackage

`default_nettype wire

// ==== design/pc_cmd_decode.sv ====
`default_nettype none

module pc_cmd_decode
	import pc_ctrl_pkg::*;
#(
	parameter int NUM_BYTES = 2
) (
	input  wire logic                       phi2,
	input  wire logic                       rst_n,
	input  wire logic                       cmd_valid,
	input  wire pc_cmd_t                    cmd,
	output pc_xfer_t        [NUM_BYTES-1:0] xfer,
	output logic                            carry_in,
	output logic            [DB_SEL_W-1:0]  db_sel,
	output logic                            db_en
);

	logic [MAX_PC_BYTES-1:0] load_legal;
	logic [MAX_PC_BYTES-1:0] load_stray;

	// Per-byte control, all idle without a strobe
	for (genvar k = 0; k < NUM_BYTES; k++) begin : g_xfer
		assign xfer[k] = xfer_for_byte(cmd_valid, cmd, k);
	end

	// Increment enters at the low byte only
	assign carry_in = cmd_valid && cmd.inc;

	always_comb begin
		db_en  = 1'b0;
		db_sel = '0;
		if (cmd_valid) begin
			db_en  = cmd.db_drive;
			db_sel = cmd.db_sel;
		end
	end

	// Load bits for bytes that this counter does not have
	assign load_legal = legal_load_mask(NUM_BYTES);
	assign load_stray = cmd.load_mask & ~load_legal;

	a_num_bytes: assert property (
		@(posedge phi2)
		(NUM_BYTES >= 1) && (NUM_BYTES <= MAX_PC_BYTES)
	) else $error("NUM_BYTES %0d outside 1..%0d", NUM_BYTES, MAX_PC_BYTES);

	// Bus driver relies on this for its DB mux
	a_db_sel: assert property (
		@(posedge phi2) disable iff (!rst_n)
		cmd_valid && cmd.db_drive |-> (int'(cmd.db_sel) < NUM_BYTES)
	) else $error("db_sel %0d beyond %0d bytes", cmd.db_sel, NUM_BYTES);

	// A stray bit would be dropped silently by the slices
	a_load_mask: assert property (
		@(posedge phi2) disable iff (!rst_n)
		cmd_valid |-> (load_stray == '0)
	) else $error("load_mask %b beyond %0d bytes", cmd.load_mask, NUM_BYTES);

endmodule

`default_nettype wire

// ==== design/pc_byte_slice.sv ====
`default_nettype none

module pc_byte_slice
	import cpu_bus_pkg::*;
	import pc_ctrl_pkg::*;
(
	input  wire logic      phi2,
	input  wire logic      rst_n,
	input  wire pc_xfer_t  xfer,
	input  wire bus_byte_t ad_in,
	input  wire logic      carry_in,
	output logic           carry_out,
	output bus_byte_t      pc_byte,
	output logic           drive_ad
);

	bus_byte_t pc_sel;  // PCLS/PCHS
	bus_byte_t pc_next;
	bus_byte_t pc_q;    // PCL/PCH

	// Select stage, bus load or hold
	always_comb begin
		pc_sel = pc_q;
		if (xfer.load_ad) begin
			pc_sel = ad_in;
		end
	end

	// Carry is taken from the selected value, not from the register
	assign carry_out = byte_carry(carry_in, pc_sel);

	assign pc_next = pc_sel + bus_byte_t'(carry_in); // Wraps mod 256

	always_ff @(posedge phi2 or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_byte  = pc_q;
	assign drive_ad = xfer.drive_ad;

	// A carry out means this byte wrapped to 00 at the edge
	a_carry_wrap: assert property (
		@(posedge phi2) disable iff (!rst_n)
		carry_out |-> carry_in ##1 (pc_q == '0)
	) else $error("carry out without carry in or without wrap, byte %h", pc_q);

endmodule

`default_nettype wire

// ==== design/pc_bus_drive.sv ====
`default_nettype none

module pc_bus_drive
	import cpu_bus_pkg::*;
	import pc_ctrl_pkg::*;
#(
	parameter int NUM_BYTES = 2
) (
	input  wire bus_byte_t [NUM_BYTES-1:0] pc_bytes,
	input  wire logic      [NUM_BYTES-1:0] drive_ad,
	input  wire logic      [DB_SEL_W-1:0]  db_sel,
	input  wire logic                      db_en,
	output bus_byte_t      [NUM_BYTES-1:0] ad_out,
	output logic           [NUM_BYTES-1:0] ad_out_en,
	output bus_byte_t                      db_out,
	output logic                           db_out_en
);

	bus_byte_t db_byte;

	// Each byte owns its address bus
	for (genvar k = 0; k < NUM_BYTES; k++) begin : g_ad
		assign ad_out[k] = bus_gate(drive_ad[k], pc_bytes[k]);
	end

	assign ad_out_en = drive_ad;

	// DB mux, an index past the top byte selects nothing
	always_comb begin
		db_byte = BUS_IDLE;
		for (int k = 0; k < NUM_BYTES; k++) begin
			if (int'(db_sel) == k) begin
				db_byte = pc_bytes[k];
			end
		end
	end

	assign db_out    = bus_gate(db_en, db_byte);
	assign db_out_en = db_en;

	// Decoder must never enable DB with a missing byte
	always_comb begin
		if (db_out_en) begin
			a_db_range: assert (int'(db_sel) < NUM_BYTES)
			else $error("DB enabled for byte %0d of %0d", db_sel, NUM_BYTES);
		end
	end

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
`default_nettype none

module pc_unit
	import cpu_bus_pkg::*;
	import pc_ctrl_pkg::*;
#(
	parameter int NUM_BYTES = 2
) (
	input  wire logic                      phi2,
	input  wire logic                      rst_n,
	input  wire logic                      cmd_valid,
	input  wire pc_cmd_t                   cmd,
	input  wire bus_byte_t [NUM_BYTES-1:0] ad_in,
	output bus_byte_t      [NUM_BYTES-1:0] ad_out,
	output logic           [NUM_BYTES-1:0] ad_out_en,
	output bus_byte_t                      db_out,
	output logic                           db_out_en
);

	pc_xfer_t  [NUM_BYTES-1:0] xfer;
	logic      [NUM_BYTES:0]   carry;    // Top bit is the whole counter wrapping
	bus_byte_t [NUM_BYTES-1:0] pc_bytes;
	logic      [NUM_BYTES-1:0] drive_ad;
	logic      [DB_SEL_W-1:0]  db_sel;
	logic                      db_en;

	pc_cmd_decode #(
		.NUM_BYTES(NUM_BYTES)
	) i_decode (
		.phi2     (phi2),
		.rst_n    (rst_n),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.xfer     (xfer),
		.carry_in (carry[0]),
		.db_sel   (db_sel),
		.db_en    (db_en)
	);

	// Byte 0 is PCL on ADL, byte 1 is PCH on ADH
	for (genvar k = 0; k < NUM_BYTES; k++) begin : g_byte
		pc_byte_slice i_slice (
			.phi2     (phi2),
			.rst_n    (rst_n),
			.xfer     (xfer[k]),
			.ad_in    (ad_in[k]),
			.carry_in (carry[k]),
			.carry_out(carry[k+1]),
			.pc_byte  (pc_bytes[k]),
			.drive_ad (drive_ad[k])
		);
	end

	pc_bus_drive #(
		.NUM_BYTES(NUM_BYTES)
	) i_drive (
		.pc_bytes (pc_bytes),
		.drive_ad (drive_ad),
		.db_sel   (db_sel),
		.db_en    (db_en),
		.ad_out   (ad_out),
		.ad_out_en(ad_out_en),
		.db_out   (db_out),
		.db_out_en(db_out_en)
	);

endmodule

`default_nettype wire

// ==== bench/pc_unit_tb.sv ====
`default_nettype none

module pc_unit_tb
	import cpu_bus_pkg::*;
	import pc_ctrl_pkg::*;
();

	localparam int          NUM_BYTES     = 2;
	localparam int          VEC_WORDS     = 12; // Columns per stimulus line
	localparam int          MAX_VECS      = 64;
	localparam logic [7:0]  END_MARK      = 8'hff;
	localparam int          RESET_TIMEOUT = 10;
	localparam int          DRAIN_TIMEOUT = 8;
	localparam logic [31:0] RAND_SEED     = 32'hc1a1;
	localparam string       STIM_FILE     = "bench/pc_stimulus.txt";

	logic                      phi2;
	logic                      rst_n;
	logic                      cmd_valid;
	pc_cmd_t                   cmd;
	bus_byte_t [NUM_BYTES-1:0] ad_in;
	bus_byte_t [NUM_BYTES-1:0] ad_out;
	logic      [NUM_BYTES-1:0] ad_out_en;
	bus_byte_t                 db_out;
	logic                      db_out_en;

	logic [7:0] stim_mem [0:VEC_WORDS*MAX_VECS-1];

	pc_unit #(
		.NUM_BYTES(NUM_BYTES)
	) i_dut (
		.phi2     (phi2),
		.rst_n    (rst_n),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.ad_in    (ad_in),
		.ad_out   (ad_out),
		.ad_out_en(ad_out_en),
		.db_out   (db_out),
		.db_out_en(db_out_en)
	);

	always #2 phi2 = ~phi2;

	initial begin : reset_gen
		rst_n = 1'b0;
		repeat (3) @(posedge phi2);
		rst_n <= 1'b1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_addr(
		input string                     where,
		input bus_byte_t [NUM_BYTES-1:0] got,
		input bus_byte_t [NUM_BYTES-1:0] exp,
		input logic      [NUM_BYTES-1:0] got_en,
		input logic      [NUM_BYTES-1:0] exp_en
	);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED ad_out at %s: got %h expected %h",
				where, got, exp));
		end
		if (got_en !== exp_en) begin
			abort_run($sformatf("CHECK FAILED ad_out_en at %s: got %h expected %h",
				where, got_en, exp_en));
		end
	endtask

	task automatic check_db(
		input string     where,
		input bus_byte_t got,
		input bus_byte_t exp,
		input logic      got_en,
		input logic      exp_en
	);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED db_out at %s: got %h expected %h",
				where, got, exp));
		end
		if (got_en !== exp_en) begin
			abort_run($sformatf("CHECK FAILED db_out_en at %s: got %h expected %h",
				where, got_en, exp_en));
		end
	endtask

	// No strobe, so nothing may drive
	task automatic check_idle(input string where);
		check_addr(where, ad_out, '0, ad_out_en, '0);
		check_db(where, db_out, 8'h00, db_out_en, 1'b0);
	endtask

	task automatic drive_idle();
		bus_byte_t [NUM_BYTES-1:0] noise;
		for (int k = 0; k < NUM_BYTES; k++) begin
			noise[k] = bus_byte_t'($urandom_range(255, 0)); // Bus junk must be ignored
		end
		cmd_valid <= 1'b0;
		cmd       <= '0;
		ad_in     <= noise;
	endtask

	initial begin : main
		int                        vec;
		int                        base;
		int                        gap;
		int                        wait_cycles;
		logic                      done;
		pc_cmd_t                   cmd_v;
		bus_byte_t [NUM_BYTES-1:0] ad_v;
		bus_byte_t [NUM_BYTES-1:0] exp_ad;
		logic      [NUM_BYTES-1:0] exp_ad_en;
		bus_byte_t                 exp_db;
		logic                      exp_db_en;

		phi2       = 1'b0;
		cmd_valid  = 1'b0;
		cmd        = '0;
		ad_in      = '0;
		void'($urandom(RAND_SEED));
		$readmemh(STIM_FILE, stim_mem);

		wait_cycles = 0;
		while (rst_n !== 1'b1) begin
			if (wait_cycles >= RESET_TIMEOUT) begin
				abort_run("reset was never released");
			end
			@(posedge phi2);
			wait_cycles++;
		end
		@(negedge phi2);
		check_idle("reset release");
		@(posedge phi2);

		vec  = 0;
		done = 1'b0;
		while (!done) begin
			if (vec >= MAX_VECS) begin
				abort_run("stimulus file has no end marker within the vector limit");
			end
			base = vec * VEC_WORDS;
			if (stim_mem[base] == END_MARK) begin
				done = 1'b1;
			end else begin
				cmd_v.inc        = stim_mem[base][0];
				cmd_v.load_mask  = stim_mem[base + 1][MAX_PC_BYTES-1:0];
				cmd_v.addr_drive = stim_mem[base + 2][0];
				cmd_v.db_drive   = stim_mem[base + 3][0];
				cmd_v.db_sel     = stim_mem[base + 4][DB_SEL_W-1:0];
				ad_v[1]          = stim_mem[base + 5]; // ADH
				ad_v[0]          = stim_mem[base + 6]; // ADL
				exp_ad[1]        = stim_mem[base + 7];
				exp_ad[0]        = stim_mem[base + 8];
				exp_ad_en        = stim_mem[base + 9][NUM_BYTES-1:0];
				exp_db           = stim_mem[base + 10];
				exp_db_en        = stim_mem[base + 11][0];

				cmd_valid <= 1'b1;
				cmd       <= cmd_v;
				ad_in     <= ad_v;
				@(negedge phi2); // Strobe cycle shows the old count
				check_addr($sformatf("vector %0d", vec), ad_out, exp_ad, ad_out_en, exp_ad_en);
				check_db($sformatf("vector %0d", vec), db_out, exp_db, db_out_en, exp_db_en);

				gap = int'($urandom_range(3, 0));
				@(posedge phi2);
				for (int g = 0; g < gap; g++) begin
					drive_idle();
					@(negedge phi2);
					check_idle($sformatf("idle after vector %0d", vec));
					@(posedge phi2);
				end
				vec++;
			end
		end

		drive_idle();
		@(negedge phi2);
		wait_cycles = 0;
		while ((ad_out_en !== '0) || (db_out_en !== 1'b0)) begin
			if (wait_cycles >= DRAIN_TIMEOUT) begin
				abort_run("bus enables stayed high after the last command");
			end
			@(negedge phi2);
			wait_cycles++;
		end
		check_idle("end of run");

		if (vec > 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("no stimulus vectors were read");
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== bench/pc_stimulus.txt ====
// inc load_mask addr_drive db_drive db_sel ad_in_hi ad_in_lo  exp_ad_hi exp_ad_lo exp_ad_en  exp_db exp_db_en
// A line whose first column is ff ends the list
// Value after reset, no increment
00 00 01 00 00 00 00  00 00 03  00 00
// Plain increments, each read shows the count before the step
01 00 01 00 00 00 00  00 00 03  00 00
01 00 01 00 00 00 00  00 01 03  00 00
01 00 01 00 00 00 00  00 02 03  00 00
01 00 00 00 00 00 00  00 00 00  00 00
00 00 01 00 00 00 00  00 04 03  00 00
// Load 00fe, then step across the low byte wrap
00 03 01 00 00 00 fe  00 04 03  00 00
01 00 01 00 00 00 00  00 fe 03  00 00
01 00 01 00 00 00 00  00 ff 03  00 00
00 00 01 00 00 00 00  01 00 03  00 00
// Load c0ff with inc, carry comes from the loaded low byte
01 03 01 00 00 c0 ff  01 00 03  00 00
00 00 01 00 00 00 00  c1 00 03  00 00
// Load low byte only, then high byte only, then wrap ffff
00 01 01 00 00 33 ff  c1 00 03  00 00
00 02 01 00 00 ff 44  c1 ff 03  00 00
00 00 01 00 00 00 00  ff ff 03  00 00
01 00 01 00 00 00 00  ff ff 03  00 00
00 00 01 00 00 00 00  00 00 03  00 00
// Silent load of 1234
00 03 00 00 00 12 34  00 00 00  00 00
// Data bus reads, low byte then high byte
00 00 00 01 00 00 00  00 00 00  34 01
00 00 00 01 01 00 00  00 00 00  12 01
00 00 01 01 00 00 00  12 34 03  34 01
01 00 01 01 01 00 00  12 34 03  12 01
00 00 00 01 00 00 00  00 00 00  35 01
// High byte load with inc, low byte steps without carry
01 02 01 00 00 56 99  12 35 03  00 00
00 00 01 01 01 00 00  56 36 03  56 01
00 00 00 01 00 00 00  00 00 00  36 01
01 00 00 00 00 00 00  00 00 00  00 00
00 00 01 01 00 00 00  56 37 03  37 01
// Load 12ff with no drive, then step into the high byte
00 03 00 00 00 12 ff  00 00 00  00 00
01 00 00 01 00 00 00  00 00 00  ff 01
00 00 01 01 01 00 00  13 00 03  13 01
// End of list
ff 00 00 00 00 00 00  00 00 00  00 00

// ==== sim.f ====
design/cpu_bus_pkg.sv
design/pc_ctrl_pkg.sv
design/pc_cmd_decode.sv
design/pc_byte_slice.sv
design/pc_bus_drive.sv
design/pc_unit.sv
bench/pc_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module pc_unit_tb -f sim.f -o pc_unit_sim \
	|| { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/pc_unit_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "Everything OK" && exit 0 || exit 1
